// ==== dv/blocking_cache_sva.sv ====
// Blocking cache handshake checks
// Port exclusion, payload stability under back-pressure, reset values
`default_nettype none

module blocking_cache_sva (
  input logic                                 clk,
  input logic                                 reset,
  input logic                                 cachereq_rdy,
  input logic                                 cacheresp_val,
  input logic                                 cacheresp_rdy,
  input mem_msg_pkg::msg_type_t               cacheresp_type,
  input logic [mem_msg_pkg::opaque_nbits-1:0] cacheresp_opaque,
  input logic                                 cacheresp_hit,
  input logic [31:0]                          cacheresp_data,
  input logic                                 memreq_val,
  input logic                                 memreq_rdy,
  input mem_msg_pkg::msg_type_t               memreq_type,
  input logic [31:0]                          memreq_addr,
  input logic [31:0]                          memreq_data,
  input logic                                 memresp_rdy
);

  int unsigned fail_count = 0;  // Number of failed assertions

  // Blocking cache, never takes a request while a response is pending
  req_resp_exclusive: assert property (@(posedge clk) disable iff (reset)
    !(cachereq_rdy && cacheresp_val))
    else begin
      $error("cachereq_rdy and cacheresp_val high together");
      fail_count++;
    end

  // Response held until taken
  resp_stable: assert property (@(posedge clk) disable iff (reset)
    (cacheresp_val && !cacheresp_rdy) |=> (cacheresp_val &&
      $stable({cacheresp_type, cacheresp_opaque, cacheresp_hit, cacheresp_data})))
    else begin
      $error("cache response changed under back-pressure");
      fail_count++;
    end

  // Memory request held until taken
  memreq_stable: assert property (@(posedge clk) disable iff (reset)
    (memreq_val && !memreq_rdy) |=> (memreq_val &&
      $stable({memreq_type, memreq_addr, memreq_data})))
    else begin
      $error("memory request changed under back-pressure");
      fail_count++;
    end

  // Idle handshake values after a reset edge
  reset_values: assert property (@(posedge clk)
    reset |=> (cachereq_rdy && !cacheresp_val && !memreq_val && !memresp_rdy))
    else begin
      $error("handshake outputs not at reset values");
      fail_count++;
    end

endmodule

`default_nettype wire

// ==== dv/blocking_cache_tb.sv ====
// Blocking cache testbench
// Memory model, shadow reference model and directed tests for the cache ports
`default_nettype none

module blocking_cache_tb;
  import mem_msg_pkg::*;
  import cache_cfg_pkg::*;

  localparam int n_tests    = 6;
  localparam int clk_period = 4;

  logic clk;
  logic reset;
  logic cachereq_val, cachereq_rdy, cacheresp_val, cacheresp_rdy, cacheresp_hit;
  logic memreq_val, memreq_rdy, memresp_val, memresp_rdy;
  msg_type_t cachereq_type, cacheresp_type, memreq_type;
  logic [opaque_nbits-1:0] cachereq_opaque, cacheresp_opaque;
  logic [31:0] cachereq_addr, cachereq_data, cacheresp_data, memreq_addr, memreq_data;
  line_t memresp_data;

  logic [31:0]          mem_words [logic [29:0]];  // Memory model contents
  logic [31:0]          ref_mem [logic [29:0]];    // Reference copy of memory
  logic                 shadow_valid [nlines];
  logic [tag_nbits-1:0] shadow_tag [nlines];
  logic [31:0]          shadow_line [nlines][4];   // Expected cached words
  mem_req_t             memreq_log [$];            // Requests seen in one access
  int                   n_errors = 0;

  clock_gen clock_gen_inst (.clk(clk));

  blocking_cache blocking_cache_inst (.*);

  bind blocking_cache blocking_cache_sva blocking_cache_sva_inst (.*);

  // --------------------------------------------------
  // Failure reporting and compare tasks
  task automatic stop_with_failure();
    n_errors++;
    $display("Finished with errors");
    $fatal(1, "stopping at the first failure");
  endtask

  task automatic check_resp(input cache_resp_t got, input cache_resp_t exp, input string what);
    if (got !== exp) begin
      $display("** Error @ %0t: %s got type %0d op %h hit %b data %h", $time, what,
               got.msg_type, got.opaque, got.hit, got.data);
      $display("   expected type %0d op %h hit %b data %h",
               exp.msg_type, exp.opaque, exp.hit, exp.data);
      stop_with_failure();
    end
  endtask

  task automatic check_memreq(input mem_req_t got, input mem_req_t exp);
    if (got !== exp) begin
      $display("** Error @ %0t: memreq got type %0d addr %h data %h, expected %0d %h %h",
               $time, got.msg_type, got.addr, got.data, exp.msg_type, exp.addr, exp.data);
      stop_with_failure();
    end
  endtask

  // Background pattern, a function of the full word address
  function automatic logic [31:0] fill_word(input logic [29:0] waddr);
    fill_word = ({waddr, 2'b01} * 32'h9e3779b1) ^ 32'h5bd1e995;
  endfunction

  function automatic logic [31:0] mem_read(input logic [29:0] waddr);
    mem_read = mem_words.exists(waddr) ? mem_words[waddr] : fill_word(waddr);
  endfunction

  function automatic logic [31:0] ref_word(input logic [29:0] waddr);
    ref_word = ref_mem.exists(waddr) ? ref_mem[waddr] : fill_word(waddr);
  endfunction

  function automatic cache_resp_t sample_resp();
    sample_resp = '{msg_type: cacheresp_type, opaque: cacheresp_opaque,
                    hit: cacheresp_hit, data: cacheresp_data};
  endfunction

  // --------------------------------------------------
  // Memory model, accepts after 0 to 3 cycles, answers one cycle later
  initial begin : memory_model
    mem_req_t req;
    line_t    line;
    int       delay;
    memreq_rdy   = 1'b0;
    memresp_val  = 1'b0;
    memresp_data = '0;
    forever begin
      @(posedge clk);
      if (!reset && memreq_val) begin
        delay = $urandom_range(0, 3);
        repeat (delay) @(posedge clk);
        memreq_rdy <= 1'b1;
        @(posedge clk);                    // Transfer edge
        memreq_rdy <= 1'b0;
        req = '{msg_type: memreq_type, addr: memreq_addr, data: memreq_data};
        memreq_log.push_back(req);
        if (req.msg_type == msg_write) mem_words[req.addr[31:2]] = req.data;
        for (int w = 0; w < 4; w++) line[32*w +: 32] = mem_read({req.addr[31:4], 2'(w)});
        memresp_val  <= 1'b1;              // Refill line, or ack for a write
        memresp_data <= line;
        @(posedge clk);
        while (!memresp_rdy) @(posedge clk);  // Held until the cache takes it
        memresp_val  <= 1'b0;
      end
    end
  end

  // --------------------------------------------------
  // One request with reference prediction, memreq and response checks
  task automatic access(input msg_type_t t, input logic [31:0] addr, input logic [31:0] data,
                        input logic [7:0] opaque, input int max_stall);
    cache_resp_t          exp_resp;
    cache_resp_t          got;
    mem_req_t             exp_mreq;
    logic [tag_nbits-1:0] tag;
    int                   idx;
    int                   word;
    int                   n_exp;
    int                   stall;
    logic                 exp_hit;
    idx      = addr[off_nbits +: idx_nbits];
    tag      = addr[31 -: tag_nbits];
    word     = addr[3:2];
    exp_hit  = shadow_valid[idx] && (shadow_tag[idx] == tag);
    exp_resp = '{msg_type: t, opaque: opaque, hit: exp_hit, data: 32'd0};
    exp_mreq = '{msg_type: msg_read, addr: {addr[31:4], 4'd0}, data: 32'd0};
    n_exp    = 0;
    case (t)
      msg_init: begin
        shadow_tag[idx]         = tag;
        shadow_valid[idx]       = 1'b1;
        shadow_line[idx][word]  = data;
      end
      msg_read: begin
        if (!exp_hit) begin                // Line refill from memory
          n_exp = 1;
          shadow_tag[idx]   = tag;
          shadow_valid[idx] = 1'b1;
          for (int w = 0; w < 4; w++) shadow_line[idx][w] = ref_word({addr[31:4], 2'(w)});
        end
        exp_resp.data = shadow_line[idx][word];
      end
      default: begin                       // Write through, no allocate
        n_exp    = 1;
        exp_mreq = '{msg_type: msg_write, addr: addr, data: data};
        ref_mem[addr[31:2]] = data;
        if (exp_hit) shadow_line[idx][word] = data;
      end
    endcase
    memreq_log.delete();
    @(posedge clk);
    cachereq_val    <= 1'b1;
    cachereq_type   <= t;
    cachereq_opaque <= opaque;
    cachereq_addr   <= addr;
    cachereq_data   <= data;
    @(posedge clk);
    while (!cachereq_rdy) @(posedge clk);
    cachereq_val <= 1'b0;
    @(posedge clk);
    while (!cacheresp_val) @(posedge clk);
    got = sample_resp();
    check_resp(got, exp_resp, "response");
    stall = $urandom_range(0, max_stall);
    repeat (stall) begin                   // Response must hold while not taken
      @(posedge clk);
      if (!cacheresp_val) begin
        $display("Response valid dropped before the response was taken");
        stop_with_failure();
      end
      check_resp(sample_resp(), exp_resp, "held response");
    end
    cacheresp_rdy <= 1'b1;
    @(posedge clk);
    cacheresp_rdy <= 1'b0;
    if (memreq_log.size() != n_exp) begin
      $display("Expected %0d memory requests at %h, saw %0d", n_exp, addr, memreq_log.size());
      stop_with_failure();
    end
    if (n_exp == 1) check_memreq(memreq_log[0], exp_mreq);
  endtask

  // --------------------------------------------------
  // Directed tests
  task automatic test_init_read();
    access(msg_init, 32'h0000_1234, 32'h1357_9bdf, 8'h01, 0);
    access(msg_read, 32'h0000_1234, 32'h0, 8'h02, 0);  // Hit on the init word
  endtask

  task automatic test_read_miss_hit();
    access(msg_read, 32'h0000_3580, 32'h0, 8'h10, 0);  // Miss, line refill
    access(msg_read, 32'h0000_3584, 32'h0, 8'h11, 0);
    access(msg_read, 32'h0000_358c, 32'h0, 8'h12, 0);
  endtask

  task automatic test_write_hit();
    access(msg_read, 32'h0000_46a8, 32'h0, 8'h20, 0);
    access(msg_write, 32'h0000_46a8, 32'hcafe_0001, 8'h21, 0);
    access(msg_read, 32'h0000_46a8, 32'h0, 8'h22, 0);  // New data from the array
  endtask

  task automatic test_write_miss();
    access(msg_write, 32'h0000_57c4, 32'hbeef_0042, 8'h30, 0);
    access(msg_read, 32'h0000_57c4, 32'h0, 8'h31, 0);  // Still a miss
  endtask

  task automatic test_conflict();
    for (int i = 0; i < 4; i++) begin
      access(msg_read, (i % 2) ? 32'h0001_0a40 : 32'h0000_0a40, 32'h0, 8'(8'h40 + i), 0);
    end
  endtask

  task automatic test_back_pressure();
    logic [31:0] addr;
    msg_type_t   t;
    for (int i = 0; i < 12; i++) begin
      addr = 32'h0000_2000 | (32'($urandom_range(0, 511)) & 32'h0000_01fc);
      t    = $urandom_range(0, 1) ? msg_write : msg_read;
      access(t, addr, $urandom, 8'($urandom_range(0, 255)), 5);
    end
  endtask

  // --------------------------------------------------
  initial begin : watchdog
    #(n_tests * 200 * clk_period);
    $display("Timeout: the tests did not finish in %0d time units", n_tests * 200 * clk_period);
    stop_with_failure();
  end

  // Handshake assertion watch
  initial begin : assertion_monitor
    wait (blocking_cache_inst.blocking_cache_sva_inst.fail_count != 0);
    $display("A handshake assertion in blocking_cache_sva failed");
    stop_with_failure();
  end

  initial begin : run
    void'($urandom(32'h3f7d7bb6));
    reset           = 1'b1;
    cachereq_val    = 1'b0;
    cachereq_type   = msg_read;
    cachereq_opaque = '0;
    cachereq_addr   = '0;
    cachereq_data   = '0;
    cacheresp_rdy   = 1'b0;
    for (int i = 0; i < nlines; i++) shadow_valid[i] = 1'b0;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    test_init_read();
    test_read_miss_hit();
    test_write_hit();
    test_write_miss();
    test_conflict();
    test_back_pressure();
    if (n_errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== dv/clock_gen.sv ====
// Testbench clock source, period of 4
`default_nettype none

module clock_gen (
  output logic clk
);
  localparam int half_period = 2;  // Two units high, two units low

  initial begin
    clk = 1'b0;
    forever #half_period clk = ~clk;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
verilog/mem_msg_pkg.sv
verilog/cache_cfg_pkg.sv
verilog/cache_ctrl_if.sv
verilog/cache_ctrl.sv
verilog/cache_dpath.sv
verilog/blocking_cache.sv
dv/clock_gen.sv
dv/blocking_cache_sva.sv
dv/blocking_cache_tb.sv

// ==== verilog/blocking_cache.sv ====
// Blocking direct-mapped write-through cache
// Joins the FSM and the datapath, exposes the cache and memory ports
`default_nettype none

module blocking_cache (
  input  logic                                   clk,
  input  logic                                   reset,

  // Cache request
  input  logic                                   cachereq_val,
  output logic                                   cachereq_rdy,
  input  mem_msg_pkg::msg_type_t                 cachereq_type,
  input  logic [mem_msg_pkg::opaque_nbits-1:0]   cachereq_opaque,
  input  logic [31:0]                            cachereq_addr,
  input  logic [31:0]                            cachereq_data,

  // Cache response
  output logic                                   cacheresp_val,
  input  logic                                   cacheresp_rdy,
  output mem_msg_pkg::msg_type_t                 cacheresp_type,
  output logic [mem_msg_pkg::opaque_nbits-1:0]   cacheresp_opaque,
  output logic                                   cacheresp_hit,
  output logic [31:0]                            cacheresp_data,

  // Memory request
  output logic                                   memreq_val,
  input  logic                                   memreq_rdy,
  output mem_msg_pkg::msg_type_t                 memreq_type,
  output logic [31:0]                            memreq_addr,
  output logic [31:0]                            memreq_data,

  // Memory response, one full line
  input  logic                                   memresp_val,
  output logic                                   memresp_rdy,
  input  mem_msg_pkg::line_t                     memresp_data
);

  cache_ctrl_if cif ();  // Controls and status between FSM and datapath

  // --------------------------------------------------
  // FSM owns the handshakes and the hit flag
  cache_ctrl ctrl_inst (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .cacheresp_hit (cacheresp_hit),
    .cif           (cif)
  );

  // Datapath owns the message fields
  cache_dpath dpath_inst (
    .clk              (clk),
    .reset            (reset),
    .cachereq_type    (cachereq_type),
    .cachereq_opaque  (cachereq_opaque),
    .cachereq_addr    (cachereq_addr),
    .cachereq_data    (cachereq_data),
    .cacheresp_type   (cacheresp_type),
    .cacheresp_opaque (cacheresp_opaque),
    .cacheresp_data   (cacheresp_data),
    .memreq_type      (memreq_type),
    .memreq_addr      (memreq_addr),
    .memreq_data      (memreq_data),
    .memresp_data     (memresp_data),
    .cif              (cif)
  );

endmodule

`default_nettype wire

// ==== verilog/cache_cfg_pkg.sv ====
// Cache configuration package
// Geometry of the direct-mapped cache and the controller state encoding
`default_nettype none

package cache_cfg_pkg;

  // ------------------------------------------------
  // Geometry, 16 lines of 16 bytes
  localparam int cache_nbytes   = 256;
  localparam int line_nbytes    = 16;
  localparam int nlines         = cache_nbytes / line_nbytes;  // 16
  localparam int idx_nbits      = $clog2(nlines);               // 4
  localparam int off_nbits      = $clog2(line_nbytes);          // 4
  localparam int tag_nbits      = 32 - idx_nbits - off_nbits;   // 24
  localparam int word_sel_nbits = off_nbits - 2;                // Word within the line

  // ------------------------------------------------
  // Controller states
  typedef enum logic [3:0] {
    idle          = 4'd0,   // Waiting for a request
    tag_check     = 4'd1,   // Compare tag, branch on type
    init_access   = 4'd2,   // Install tag and word
    read_access   = 4'd3,   // Load line into the read register
    write_access  = 4'd4,   // Update word on a write hit
    refill_req    = 4'd5,   // Line read to memory
    refill_wait   = 4'd6,   // Wait for the refill line
    refill_update = 4'd7,   // Write line and tag into the arrays
    wmem_req      = 4'd8,   // Write-through request
    wmem_wait     = 4'd9,   // Wait for the write ack
    resp_wait     = 4'd10   // Hold response until taken
  } ctrl_state_t;

endpackage

`default_nettype wire

// ==== verilog/cache_ctrl.sv ====
// Blocking cache controller
// FSM for tag check, data access, line refill and write-through
`default_nettype none

module cache_ctrl (
  input  logic         clk,
  input  logic         reset,
  input  logic         cachereq_val,
  output logic         cachereq_rdy,
  output logic         cacheresp_val,
  input  logic         cacheresp_rdy,
  output logic         memreq_val,
  input  logic         memreq_rdy,
  input  logic         memresp_val,
  output logic         memresp_rdy,
  output logic         cacheresp_hit,
  cache_ctrl_if.ctrl   cif
);
  import mem_msg_pkg::*;
  import cache_cfg_pkg::*;

  ctrl_state_t state_reg;
  ctrl_state_t state_next;
  logic        hit_reg;  // Hit flag captured at tag check

  // --------------------------------------------------
  // State register and hit flag
  always_ff @(posedge clk) begin
    if (reset) begin
      state_reg <= idle;
      hit_reg   <= 1'b0;
    end else begin
      state_reg <= state_next;
      if (state_reg == tag_check) hit_reg <= cif.tag_match;
    end
  end

  assign cacheresp_hit = hit_reg;

  // --------------------------------------------------
  // Next state
  always_comb begin
    state_next = state_reg;  // Stay by default, covers all stalls
    case (state_reg)
      idle:          if (cachereq_val) state_next = tag_check;
      tag_check: begin
        case (cif.req_type)
          msg_init:  state_next = init_access;
          msg_read:  state_next = cif.tag_match ? read_access : refill_req;
          msg_write: state_next = cif.tag_match ? write_access : wmem_req;
          default:   state_next = resp_wait;  // Unknown type, answer without access
        endcase
      end
      init_access:   state_next = resp_wait;
      read_access:   state_next = resp_wait;
      write_access:  state_next = wmem_req;   // Array first, then memory
      refill_req:    if (memreq_rdy) state_next = refill_wait;
      refill_wait:   if (memresp_val) state_next = refill_update;
      refill_update: state_next = read_access;  // Replay the read on the new line
      wmem_req:      if (memreq_rdy) state_next = wmem_wait;
      wmem_wait:     if (memresp_val) state_next = resp_wait;
      resp_wait:     if (cacheresp_rdy) state_next = idle;
      default:       state_next = idle;
    endcase
  end

  // --------------------------------------------------
  // Control signal table
  typedef struct packed {
    logic cachereq_rdy;
    logic cacheresp_val;
    logic memreq_val;
    logic memresp_rdy;
    logic req_en;
    logic refill_en;
    logic refill_sel;
    logic tag_wen;
    logic data_wen;
    logic read_en;
  } cs_t;

  cs_t cs;

  function automatic cs_t set_cs(
    input logic creq_rdy, input logic cresp_val,
    input logic mreq_val, input logic mresp_rdy,
    input logic req_en,   input logic refill_en, input logic refill_sel,
    input logic tag_wen,  input logic data_wen,  input logic read_en
  );
    set_cs = '{creq_rdy, cresp_val, mreq_val, mresp_rdy,
               req_en, refill_en, refill_sel, tag_wen, data_wen, read_en};
  endfunction

  // Register loads in idle and refill_wait repeat each cycle, last one is the transfer
  always_comb begin
    case (state_reg)
      //                  creq cresp mreq mresp  req  rfl  rfl  tag  data read
      //                  rdy  val   val  rdy    en   en   sel  wen  wen  en
      idle:          cs = set_cs(1, 0, 0, 0,  1, 0, 0, 0, 0, 0);
      tag_check:     cs = set_cs(0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
      init_access:   cs = set_cs(0, 0, 0, 0,  0, 0, 0, 1, 1, 0);
      read_access:   cs = set_cs(0, 0, 0, 0,  0, 0, 0, 0, 0, 1);
      write_access:  cs = set_cs(0, 0, 0, 0,  0, 0, 0, 0, 1, 0);
      refill_req:    cs = set_cs(0, 0, 1, 0,  0, 0, 0, 0, 0, 0);
      refill_wait:   cs = set_cs(0, 0, 0, 1,  0, 1, 1, 0, 0, 0);
      refill_update: cs = set_cs(0, 0, 0, 0,  0, 0, 1, 1, 1, 0);
      wmem_req:      cs = set_cs(0, 0, 1, 0,  0, 0, 0, 0, 0, 0);
      wmem_wait:     cs = set_cs(0, 0, 0, 1,  0, 0, 0, 0, 0, 0);
      resp_wait:     cs = set_cs(0, 1, 0, 0,  0, 0, 0, 0, 0, 0);
      default:       cs = set_cs(0, 0, 0, 0,  0, 0, 0, 0, 0, 0);
    endcase
  end

  // Unpack to handshake ports and datapath controls
  assign cachereq_rdy   = cs.cachereq_rdy;
  assign cacheresp_val  = cs.cacheresp_val;
  assign memreq_val     = cs.memreq_val;
  assign memresp_rdy    = cs.memresp_rdy;
  assign cif.req_en     = cs.req_en;
  assign cif.refill_en  = cs.refill_en;
  assign cif.refill_sel = cs.refill_sel;
  assign cif.tag_wen    = cs.tag_wen;
  assign cif.data_wen   = cs.data_wen;
  assign cif.read_en    = cs.read_en;

endmodule

`default_nettype wire

// ==== verilog/cache_ctrl_if.sv ====
// Controller to datapath link of the blocking cache
// Array and register enables one way, request type and tag compare the other
`default_nettype none

interface cache_ctrl_if;
  import mem_msg_pkg::*;

  // Controls, driven by the FSM
  logic      req_en;      // Load request register
  logic      refill_en;   // Load refill line register
  logic      tag_wen;     // Write tag and set valid
  logic      data_wen;    // Write data array line
  logic      refill_sel;  // 1 whole refill line, 0 one request word
  logic      read_en;     // Load read data register

  // Status, driven by the datapath
  msg_type_t req_type;    // Type of the registered request
  logic      tag_match;   // Valid and tag equal

  modport ctrl (
    output req_en, refill_en, tag_wen, data_wen, refill_sel, read_en,
    input  req_type, tag_match
  );

  modport dpath (
    input  req_en, refill_en, tag_wen, data_wen, refill_sel, read_en,
    output req_type, tag_match
  );

endinterface

`default_nettype wire

// ==== verilog/cache_dpath.sv ====
// Blocking cache datapath
// Tag, valid and data arrays, request and refill registers, message fields
`default_nettype none

module cache_dpath (
  input  logic                                   clk,
  input  logic                                   reset,
  input  mem_msg_pkg::msg_type_t                 cachereq_type,
  input  logic [mem_msg_pkg::opaque_nbits-1:0]   cachereq_opaque,
  input  logic [31:0]                            cachereq_addr,
  input  logic [31:0]                            cachereq_data,
  output mem_msg_pkg::msg_type_t                 cacheresp_type,
  output logic [mem_msg_pkg::opaque_nbits-1:0]   cacheresp_opaque,
  output logic [31:0]                            cacheresp_data,
  output mem_msg_pkg::msg_type_t                 memreq_type,
  output logic [31:0]                            memreq_addr,
  output logic [31:0]                            memreq_data,
  input  mem_msg_pkg::line_t                     memresp_data,
  cache_ctrl_if.dpath                            cif
);
  import mem_msg_pkg::*;
  import cache_cfg_pkg::*;

  cache_req_t                 req_reg;      // Request held for the whole transaction
  line_t                      refill_line;  // Line returned by memory
  line_t                      read_line;    // Line read for the response

  logic [tag_nbits-1:0]       tag_array [nlines];
  logic [nlines-1:0]          valid_bits;
  line_t                      data_array [nlines];

  logic [tag_nbits-1:0]       req_tag;
  logic [idx_nbits-1:0]       req_idx;
  logic [word_sel_nbits-1:0]  req_word;
  logic [6:0]                 word_lsb;     // Bit position of the word in a line
  line_t                      wr_line;
  mem_req_t                   mreq;

  // --------------------------------------------------
  // Request and refill registers, no reset on payload
  always_ff @(posedge clk) begin
    if (cif.req_en) begin
      req_reg <= '{msg_type: cachereq_type, opaque: cachereq_opaque,
                   addr: cachereq_addr, data: cachereq_data};
    end
    if (cif.refill_en) refill_line <= memresp_data;
  end

  // Address split: tag | index | word | byte
  assign req_tag  = req_reg.addr[31 -: tag_nbits];
  assign req_idx  = req_reg.addr[off_nbits +: idx_nbits];
  assign req_word = req_reg.addr[(off_nbits - word_sel_nbits) +: word_sel_nbits];
  assign word_lsb = {req_word, 5'd0};

  assign cif.req_type  = req_reg.msg_type;
  assign cif.tag_match = valid_bits[req_idx] && (tag_array[req_idx] == req_tag);

  // --------------------------------------------------
  // Array write data
  always_comb begin
    wr_line = data_array[req_idx];  // Keep other words of the line
    if (cif.refill_sel) begin
      wr_line = refill_line;        // Whole line on refill
    end else begin
      wr_line[word_lsb +: 32] = req_reg.data;
    end
  end

  // Tag and data arrays
  always_ff @(posedge clk) begin
    if (cif.tag_wen)  tag_array[req_idx]  <= req_tag;
    if (cif.data_wen) data_array[req_idx] <= wr_line;
    if (cif.read_en)  read_line           <= data_array[req_idx];
  end

  // Valid bits, cleared on reset, set with the tag
  always_ff @(posedge clk) begin
    if (reset) begin
      valid_bits <= '0;
    end else if (cif.tag_wen) begin
      valid_bits[req_idx] <= 1'b1;
    end
  end

  // --------------------------------------------------
  // Memory request: line read on a miss, word write through otherwise
  always_comb begin
    if (req_reg.msg_type == msg_write) begin
      mreq = '{msg_type: msg_write, addr: req_reg.addr, data: req_reg.data};
    end else begin
      mreq = '{msg_type: msg_read,
               addr: {req_reg.addr[31:off_nbits], {off_nbits{1'b0}}},
               data: 32'd0};
    end
  end

  assign memreq_type = mreq.msg_type;
  assign memreq_addr = mreq.addr;
  assign memreq_data = mreq.data;

  // Response fields, data only meaningful on reads
  assign cacheresp_type   = req_reg.msg_type;
  assign cacheresp_opaque = req_reg.opaque;
  assign cacheresp_data   = (req_reg.msg_type == msg_read) ? read_line[word_lsb +: 32] : 32'd0;

endmodule

`default_nettype wire

// ==== verilog/mem_msg_pkg.sv ====
// Memory message package
// Request and response message formats for the cache port and the memory port
`default_nettype none

package mem_msg_pkg;

  localparam int opaque_nbits = 8;  // Width of the request tag echoed in the response

  // Request types, shared by the cache port and the memory port
  typedef enum logic [2:0] {
    msg_read  = 3'd0,
    msg_write = 3'd1,
    msg_init  = 3'd2  // Cache only, never reaches memory
  } msg_type_t;

  // ------------------------------------------------
  // Cache side messages
  typedef struct packed {
    msg_type_t                 msg_type;
    logic [opaque_nbits-1:0]   opaque;
    logic [31:0]               addr;
    logic [31:0]               data;
  } cache_req_t;

  typedef struct packed {
    msg_type_t                 msg_type;
    logic [opaque_nbits-1:0]   opaque;  // Echo of the request tag
    logic                      hit;
    logic [31:0]               data;    // Read data, zero for init and write
  } cache_resp_t;

  // ------------------------------------------------
  // Memory side messages
  typedef struct packed {
    msg_type_t   msg_type;  // Read or write only
    logic [31:0] addr;      // Line aligned on reads
    logic [31:0] data;
  } mem_req_t;

  typedef logic [127:0] line_t;  // One refill line, word 0 in the low bits

endpackage

`default_nettype wire
